//--- build.f
hw/apb_sub_pkg.sv
hw/apb_sub_if.sv
hw/xfer_fifo.sv
hw/apb_req_decode.sv
hw/apb_xfer_ctrl.sv
hw/apb_rsp_collect.sv
hw/apb_subsystem.sv
testbench/tb_clkgen.sv
testbench/apb_subsystem_assert.sv
testbench/tb_apb_subsystem.sv

//--- hw/apb_req_decode.sv
//------------------------------------------------
// Request decode stage
// Queues host requests, maps each address to a
// slot and a byte-lane strobe, and registers the
// decoded transfer for the execute stage
//------------------------------------------------
`timescale 1ns/1ns

module apb_req_decode import apb_sub_pkg::*; (
  input  logic      i_pclk,
  input  logic      i_rst_n,
  // Host request channel
  input  logic      i_req_valid,
  output logic      o_req_ready,
  input  host_req_t i_req,
  // To execute
  xfer_req_if.src   o_xfer
);

  logic              q_valid;      // Queue head present
  logic              q_ready;      // Output register can load
  host_req_t         q_req;
  logic [ADDR_W-1:0] offset;       // Address relative to slot 0
  logic [ADDR_W-SLOT_SPAN_LOG2-1:0] slot_num;
  logic              unmapped;
  slot_idx_t         slot;
  strb_t             strb;
  xfer_req_t         dec_req;
  xfer_req_t         out_q;        // Registered transfer
  logic              out_valid_q;

  xfer_fifo #(.T(host_req_t)) req_fifo_i (
    .i_pclk  (i_pclk),
    .i_rst_n (i_rst_n),
    .i_valid (i_req_valid),
    .o_ready (o_req_ready),
    .i_data  (i_req),
    .o_valid (q_valid),
    .i_ready (q_ready),
    .o_data  (q_req)
  );

  //------------------------------------------------
  // Slot window compare
  //------------------------------------------------
  assign offset   = q_req.addr - SLOT_BASE;
  assign slot_num = offset[ADDR_W-1:SLOT_SPAN_LOG2];      // 64 KB granule
  assign unmapped = (q_req.addr < SLOT_BASE) ||
                    (slot_num >= (ADDR_W-SLOT_SPAN_LOG2)'(NUM_SLOTS));
  assign slot     = unmapped ? '0 : slot_idx_t'(slot_num);

  // UART slots take one lane, little-endian order
  always_comb begin
    if (!unmapped && BYTE_LANE_SLOTS[slot]) begin
      strb = strb_t'(1) << q_req.addr[1:0];
    end else begin
      strb = '1;                         // Word slots, all lanes
    end
  end

  assign dec_req = '{req: q_req, slot: slot, strb: strb, unmapped: unmapped};

  //------------------------------------------------
  // Output register
  //------------------------------------------------
  assign q_ready = !out_valid_q || o_xfer.ready;           // Empty or draining

  always_ff @(posedge i_pclk) begin
    if (!i_rst_n) begin
      out_valid_q <= 1'b0;
    end else if (q_ready) begin
      out_valid_q <= q_valid;
    end
  end

  always_ff @(posedge i_pclk) begin
    if (q_ready && q_valid) out_q <= dec_req;
  end

  assign o_xfer.valid = out_valid_q;
  assign o_xfer.req   = out_q;

endmodule

//--- hw/apb_rsp_collect.sv
//------------------------------------------------
// Response collect stage
// Picks the finishing slot's read data on each
// completion pulse and queues host responses
//------------------------------------------------
`timescale 1ns/1ns

module apb_rsp_collect import apb_sub_pkg::*; (
  input  logic        i_pclk,
  input  logic        i_rst_n,
  // From execute
  xfer_done_if.snk    i_done,
  // APB read data of all slots
  input  prdata_bus_t i_prdata,
  // Host response channel
  output logic        o_rsp_valid,
  input  logic        i_rsp_ready,
  output xfer_rsp_t   o_rsp
);

  xfer_rsp_t rsp_in;      // Response built from the pulse
  logic      rsp_room;    // Queue can take a response

  //------------------------------------------------
  // Read data select
  //------------------------------------------------
  // prdata is only valid in the pready cycle, same cycle as the pulse
  always_comb begin
    rsp_in.err = i_done.err;
    if (i_done.err) begin
      rsp_in.rdata = '0;                  // No bus access, no data
    end else begin
      rsp_in.rdata = i_prdata[i_done.slot];
    end
  end

  xfer_fifo #(.T(xfer_rsp_t)) rsp_fifo_i (
    .i_pclk  (i_pclk),
    .i_rst_n (i_rst_n),
    .i_valid (i_done.done),
    .o_ready (rsp_room),
    .i_data  (rsp_in),
    .o_valid (o_rsp_valid),
    .i_ready (i_rsp_ready),
    .o_data  (o_rsp)
  );

  // Execute holds off new transfers while full
  assign i_done.ready = rsp_room;

endmodule

//--- hw/apb_sub_if.sv
//------------------------------------------------
// Stage links of the APB subsystem
// Decoded requests into execute, completion
// reports from execute into the result stage
//------------------------------------------------
`timescale 1ns/1ns

// Decode to execute, valid/ready
interface xfer_req_if import apb_sub_pkg::*; ();

  logic      valid;    // Decoded request waiting
  logic      ready;    // Execute can take it
  xfer_req_t req;      // Held stable while valid

  modport src (
    output valid,
    output req,
    input  ready
  );

  modport snk (
    input  valid,
    input  req,
    output ready
  );

endinterface

// Execute to result, one pulse per finished transfer
interface xfer_done_if import apb_sub_pkg::*; ();

  logic      done;     // Single-cycle completion pulse
  slot_idx_t slot;     // Slot whose read data to take
  logic      err;      // Unmapped address
  logic      ready;    // Response queue has room

  modport src (
    output done,
    output slot,
    output err,
    input  ready
  );

  modport snk (
    input  done,
    input  slot,
    input  err,
    output ready
  );

endinterface

//--- hw/apb_sub_pkg.sv
//------------------------------------------------
// APB subsystem package
// Address map of the nine peripheral slots, bus
// widths and the transfer records passed between
// the decode, execute and result stages
//------------------------------------------------
package apb_sub_pkg;

  //------------------------------------------------
  // Widths and address map
  //------------------------------------------------
  localparam int ADDR_W         = 32;         // Host and APB address
  localparam int DATA_W         = 32;         // Read and write data
  localparam int STRB_W         = 4;          // Byte lanes per word
  localparam int NUM_SLOTS      = 9;          // Peripheral slots on the bus
  localparam int SLOT_SPAN_LOG2 = 16;         // 64 KB per slot
  localparam int FIFO_DEPTH     = 2;          // Entries in each stage queue

  localparam logic [ADDR_W-1:0] SLOT_BASE = 32'h0080_0000; // Slot 0 start

  // Slots with byte-wide register files, both UARTs
  localparam logic [NUM_SLOTS-1:0] BYTE_LANE_SLOTS = 9'b1_0000_0010;

  //------------------------------------------------
  // Types
  //------------------------------------------------
  typedef logic [3:0]           slot_idx_t;   // Slot number
  typedef logic [STRB_W-1:0]    strb_t;       // Byte-lane strobe
  typedef logic [NUM_SLOTS-1:0] sel_vec_t;    // One-hot psel

  // Read data of every slot, word s from slot s
  typedef logic [NUM_SLOTS-1:0][DATA_W-1:0] prdata_bus_t;

  // Raw host request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
  } host_req_t;

  // Request after slot decode
  typedef struct packed {
    host_req_t req;
    slot_idx_t slot;
    strb_t     strb;
    logic      unmapped;     // Outside the slot window
  } xfer_req_t;

  // Response back to the host
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } xfer_rsp_t;

  // APB phases of the execute stage
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } xfer_state_t;

endpackage

//--- hw/apb_subsystem.sv
//------------------------------------------------
// APB subsystem bridge top
// Host valid/ready requests in, APB transfers to
// nine peripheral slots, responses out
//------------------------------------------------
`timescale 1ns/1ns

module apb_subsystem import apb_sub_pkg::*; (
  input  logic                 i_pclk,
  input  logic                 i_rst_n,
  // Host request
  input  logic                 i_req_valid,
  output logic                 o_req_ready,
  input  logic [ADDR_W-1:0]    i_req_addr,
  input  logic                 i_req_write,
  input  logic [DATA_W-1:0]    i_req_wdata,
  // Host response
  output logic                 o_rsp_valid,
  input  logic                 i_rsp_ready,
  output logic [DATA_W-1:0]    o_rsp_rdata,
  output logic                 o_rsp_err,
  // APB
  output sel_vec_t             o_psel,
  output logic                 o_penable,
  output logic                 o_pwrite,
  output logic [ADDR_W-1:0]    o_paddr,
  output logic [DATA_W-1:0]    o_pwdata,
  output strb_t                o_pstrb,
  input  prdata_bus_t          i_prdata,
  input  logic [NUM_SLOTS-1:0] i_pready
);

  host_req_t host_req;       // Packed host request
  xfer_rsp_t host_rsp;       // Head of response queue

  assign host_req.addr  = i_req_addr;
  assign host_req.write = i_req_write;
  assign host_req.wdata = i_req_wdata;

  assign o_rsp_rdata = host_rsp.rdata;
  assign o_rsp_err   = host_rsp.err;

  //------------------------------------------------
  // Stage links
  //------------------------------------------------
  xfer_req_if  xfer_req_bus ();
  xfer_done_if xfer_done_bus ();

  apb_req_decode decode_i (
    .i_pclk      (i_pclk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req       (host_req),
    .o_xfer      (xfer_req_bus.src)
  );

  apb_xfer_ctrl exec_i (
    .i_pclk    (i_pclk),
    .i_rst_n   (i_rst_n),
    .i_xfer    (xfer_req_bus.snk),
    .o_done    (xfer_done_bus.src),
    .o_psel    (o_psel),
    .o_penable (o_penable),
    .o_pwrite  (o_pwrite),
    .o_paddr   (o_paddr),
    .o_pwdata  (o_pwdata),
    .o_pstrb   (o_pstrb),
    .i_pready  (i_pready)
  );

  apb_rsp_collect result_i (
    .i_pclk      (i_pclk),
    .i_rst_n     (i_rst_n),
    .i_done      (xfer_done_bus.snk),
    .i_prdata    (i_prdata),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp       (host_rsp)
  );

endmodule

//--- hw/apb_xfer_ctrl.sv
//------------------------------------------------
// APB execute stage
// Runs setup and access phases for one decoded
// transfer at a time, waits on the slot's pready
// and reports completion to the result stage
//------------------------------------------------
`timescale 1ns/1ns

module apb_xfer_ctrl import apb_sub_pkg::*; (
  input  logic              i_pclk,
  input  logic              i_rst_n,
  // From decode
  xfer_req_if.snk           i_xfer,
  // To result
  xfer_done_if.src          o_done,
  // APB master side
  output sel_vec_t          o_psel,
  output logic              o_penable,
  output logic              o_pwrite,
  output logic [ADDR_W-1:0] o_paddr,
  output logic [DATA_W-1:0] o_pwdata,
  output strb_t             o_pstrb,
  input  logic [NUM_SLOTS-1:0] i_pready
);

  xfer_state_t state_q;
  xfer_state_t state_d;
  xfer_req_t   xfer_q;       // Transfer in flight
  logic        start;        // New transfer taken this cycle
  logic        done;         // Transfer ends this cycle
  logic        sel_on;       // Bus owned by a mapped slot

  // Only start when a response entry is guaranteed
  assign i_xfer.ready = (state_q == ST_IDLE) && o_done.ready;
  assign start        = i_xfer.valid && i_xfer.ready;

  // Unmapped transfers finish in the access slot without bus activity
  assign done = (state_q == ST_ACCESS) && (xfer_q.unmapped || i_pready[xfer_q.slot]);

  //------------------------------------------------
  // Phase FSM
  //------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (start) state_d = ST_SETUP;
      ST_SETUP:  state_d = ST_ACCESS;              // Setup lasts one cycle
      ST_ACCESS: if (done) state_d = ST_IDLE;      // Wait states until pready
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_pclk) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge i_pclk) begin
    if (start) xfer_q <= i_xfer.req;               // Held for both phases
  end

  //------------------------------------------------
  // APB outputs
  //------------------------------------------------
  assign sel_on    = (state_q != ST_IDLE) && !xfer_q.unmapped;
  assign o_psel    = sel_on ? (sel_vec_t'(1) << xfer_q.slot) : '0;   // One-hot
  assign o_penable = sel_on && (state_q == ST_ACCESS);
  assign o_pwrite  = xfer_q.req.write;
  assign o_paddr   = xfer_q.req.addr;
  assign o_pwdata  = xfer_q.req.wdata;
  assign o_pstrb   = xfer_q.strb;

  // Completion report
  assign o_done.done = done;
  assign o_done.slot = xfer_q.slot;
  assign o_done.err  = xfer_q.unmapped;

endmodule

//--- hw/xfer_fifo.sv
//------------------------------------------------
// Small valid/ready queue
// Circular buffer with an entry count, payload
// type set per instance
//------------------------------------------------
`timescale 1ns/1ns

module xfer_fifo import apb_sub_pkg::*; #(
  parameter type T = logic
) (
  input  logic i_pclk,
  input  logic i_rst_n,
  // Write side
  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,
  // Read side
  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  T                 mem [FIFO_DEPTH];    // Payload storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;               // Entries held
  logic             wr_en;
  logic             rd_en;

  // Full queue still takes data when the head leaves this cycle
  assign o_ready = (count != CNT_W'(FIFO_DEPTH)) || i_ready;
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign wr_en = i_valid && o_ready;
  assign rd_en = o_valid && i_ready;

  always_ff @(posedge i_pclk) begin
    if (wr_en) mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge i_pclk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;     // Push only
        2'b01:   count <= count - 1'b1;     // Pop only
        default: count <= count;            // Both or neither
      endcase
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_apb_subsystem -f build.f -o sim_apb

# Simulator status is not trusted, the log decides
./obj_dir/sim_apb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
  exit 0
else
  exit 1
fi

//--- testbench/apb_golden.txt
# op(0 read 1 write 2 held-back read) addr wdata slot(f none) strb rdata err
# all fields hex, rdata and err are the expected response
1 00800000 a5a50000 0 f 00000000 0
1 00820004 a5a50002 2 f 00000000 0
1 00830008 a5a50003 3 f 00000000 0
1 0084000c a5a50004 4 f 00000000 0
1 00850010 a5a50005 5 f 00000000 0
1 00860014 a5a50006 6 f 00000000 0
1 00870018 a5a50007 7 f 00000000 0
1 00810000 000000c1 1 1 00000000 0
1 00810001 0000c200 1 2 00000000 0
1 00810002 00c30000 1 4 00000000 0
1 00810003 c4000000 1 8 00000000 0
1 00880003 d8000000 8 8 00000000 0
0 00800020 00000000 0 f 00000020 0
0 00810024 00000000 1 1 01000024 0
0 00820028 00000000 2 f 02000028 0
0 0083002c 00000000 3 f 0300002c 0
0 00840030 00000000 4 f 04000030 0
0 00850034 00000000 5 f 05000034 0
0 00860038 00000000 6 f 06000038 0
0 0087003c 00000000 7 f 0700003c 0
0 00880010 00000000 8 1 08000010 0
0 00880011 00000000 8 2 08000011 0
0 00880012 00000000 8 4 08000012 0
0 00880013 00000000 8 8 08000013 0
0 007ffffc 00000000 f f 00000000 1
1 00890000 12345678 f f 00000000 1
2 00800100 00000000 0 f 00000100 0
2 00820104 00000000 2 f 02000104 0
2 00830108 00000000 3 f 03000108 0
2 0084010c 00000000 4 f 0400010c 0
2 00850110 00000000 5 f 05000110 0
2 00860114 00000000 6 f 06000114 0

//--- testbench/apb_subsystem_assert.sv
//------------------------------------------------
// APB subsystem checkers
// Phase order on the APB side and quiet outputs
// through reset
//------------------------------------------------
`timescale 1ns/1ns

module apb_subsystem_assert import apb_sub_pkg::*; (
  input logic     i_pclk,
  input logic     i_rst_n,
  input sel_vec_t o_psel,
  input logic     o_penable,
  input logic     o_rsp_valid
);

  // Access phase only while a slot is selected
  penable_needs_psel: assert property (@(posedge i_pclk) disable iff (!i_rst_n)
    o_penable |-> (o_psel != '0))
    else $error("penable high with no slot selected");

  // Setup lasts exactly one cycle
  access_after_setup: assert property (@(posedge i_pclk) disable iff (!i_rst_n)
    ((o_psel != '0) && !o_penable) |=> o_penable)
    else $error("penable did not follow psel by one cycle");

  reset_quiet: assert property (@(posedge i_pclk)
    !i_rst_n |=> ((o_psel == '0) && !o_penable && !o_rsp_valid))
    else $error("bus or response active during reset");

endmodule

bind apb_subsystem apb_subsystem_assert assert_i (
  .i_pclk      (i_pclk),
  .i_rst_n     (i_rst_n),
  .o_psel      (o_psel),
  .o_penable   (o_penable),
  .o_rsp_valid (o_rsp_valid)
);

//--- testbench/tb_apb_subsystem.sv
//------------------------------------------------
// APB subsystem testbench
// Golden-file stimulus, nine APB slave models with
// random wait states, response and bus checks
//------------------------------------------------
`timescale 1ns/1ns

module tb_apb_subsystem import apb_sub_pkg::*; ();

  localparam int TIMEOUT = 200;      // Cycles per wait loop

  typedef struct {
    logic [3:0] op;                  // 0 read, 1 write, 2 held-back read
    host_req_t  req;
    logic [3:0] slot;                // f when unmapped
    strb_t      strb;
    xfer_rsp_t  rsp;
  } vec_t;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid, req_ready, req_write;
  logic [ADDR_W-1:0]    req_addr, paddr;
  logic [DATA_W-1:0]    req_wdata, rsp_rdata, pwdata;
  logic                 rsp_valid, rsp_ready, rsp_err;
  logic                 penable, pwrite;
  sel_vec_t             psel;
  strb_t                pstrb;
  prdata_bus_t          prdata;
  logic [NUM_SLOTS-1:0] pready;
  logic [31:0]          lfsr_q;
  logic [1:0]           wait_bits;
  logic [2:0]           wait_cnt;    // Access cycles left before pready
  int                   errors, checks, tests;
  vec_t                 burst_q[$];

  tb_clkgen clkgen_i (.o_clk(clk), .o_rst_n(rst_n));

  apb_subsystem dut_i (
    .i_pclk      (clk),
    .i_rst_n     (rst_n),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .i_req_addr  (req_addr),
    .i_req_write (req_write),
    .i_req_wdata (req_wdata),
    .o_rsp_valid (rsp_valid),
    .i_rsp_ready (rsp_ready),
    .o_rsp_rdata (rsp_rdata),
    .o_rsp_err   (rsp_err),
    .o_psel      (psel),
    .o_penable   (penable),
    .o_pwrite    (pwrite),
    .o_paddr     (paddr),
    .o_pwdata    (pwdata),
    .o_pstrb     (pstrb),
    .i_prdata    (prdata),
    .i_pready    (pready)
  );

  //------------------------------------------------
  // Slave models
  //------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Galois taps
  endfunction

  // Wait count drawn in setup, counted down through access
  always @(posedge clk) begin
    #1;
    if ((psel != '0) && !penable) begin
      wait_bits[0] = lfsr_q[0];
      lfsr_q       = lfsr_next(lfsr_q);
      wait_bits[1] = lfsr_q[0];
      lfsr_q       = lfsr_next(lfsr_q);
      wait_cnt     = {1'b0, wait_bits} + 3'd1;
    end else if (penable && (wait_cnt != 3'd0)) begin
      wait_cnt = wait_cnt - 3'd1;
    end
  end

  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      pready[s] = psel[s] && penable && (wait_cnt == 3'd0);
      prdata[s] = (psel[s] && !pwrite) ? {8'(s), 8'h00, paddr[15:0]} : '0;
    end
  end

  //------------------------------------------------
  // Compare tasks
  //------------------------------------------------
  task automatic check_rsp(input string name, input xfer_rsp_t got, input xfer_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input sel_vec_t got, input sel_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  //------------------------------------------------
  // Host side
  //------------------------------------------------
  task automatic send_req(input host_req_t r);
    int   n;
    logic acc;
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_addr  = r.addr;
    req_write = r.write;
    req_wdata = r.wdata;
    n   = 0;
    acc = 1'b0;
    while (!acc && n < TIMEOUT) begin
      #1 acc = req_ready;            // Settled, taken on the next edge
      @(posedge clk);
      #1 n++;
    end
    req_valid = 1'b0;
    if (!acc) begin
      errors++;
      $display("request to %h was not accepted in time", r.addr);
    end
  endtask

  // One request, its APB transfer and its response
  task automatic run_single(input vec_t v);
    int        n;
    sel_vec_t  seen;
    xfer_rsp_t got;
    seen = '0;
    send_req(v.req);
    n = 0;
    while (!rsp_valid && n < TIMEOUT) begin
      if ((psel != '0) && (seen == '0)) begin      // Setup cycle
        check_strb("o_pstrb", pstrb, v.strb);
        check_word("o_paddr", paddr, v.req.addr);
        check_word("o_pwrite", 32'(pwrite), 32'(v.req.write));
        if (v.req.write) check_word("o_pwdata", pwdata, v.req.wdata);
      end
      seen |= psel;
      @(posedge clk);
      #1 n++;
    end
    check_sel("o_psel", seen, (v.slot == 4'hf) ? '0 : (sel_vec_t'(1) << v.slot));
    if (!rsp_valid) begin
      errors++;
      $display("no response for address %h", v.req.addr);
    end else begin
      got.rdata = rsp_rdata;
      got.err   = rsp_err;
      check_rsp("o_rsp", got, v.rsp);
    end
    @(posedge clk);                  // Response leaves the queue here
    #1;
  endtask

  // Responses held back until the request side stalls
  task automatic run_burst;
    int        n;
    bit        stalled;
    xfer_rsp_t got;
    rsp_ready = 1'b0;
    fork
      begin
        foreach (burst_q[i]) send_req(burst_q[i].req);
      end
      begin
        n       = 0;
        stalled = 1'b0;
        while (!stalled && n < TIMEOUT) begin
          @(posedge clk);
          #3 stalled = !req_ready;
          n++;
        end
        if (!stalled) begin
          errors++;
          $display("o_req_ready never fell while responses were held");
        end
        @(posedge clk);
        #1 rsp_ready = 1'b1;
        foreach (burst_q[i]) begin
          n = 0;
          while (!rsp_valid && n < TIMEOUT) begin
            @(posedge clk);
            #1 n++;
          end
          if (!rsp_valid) begin
            errors++;
            $display("burst response %0d never arrived", i);
          end else begin
            got.rdata = rsp_rdata;
            got.err   = rsp_err;
            check_rsp("o_rsp", got, burst_q[i].rsp);
          end
          @(posedge clk);
          #1;
        end
      end
    join
  endtask

  //------------------------------------------------
  // Main sequence
  //------------------------------------------------
  initial begin
    int          fd, k, n, err_before;
    string       line;
    vec_t        v;
    logic [31:0] f_op, f_addr, f_wdata, f_slot, f_strb, f_rdata, f_err;
    req_valid = 1'b0;
    req_addr  = '0;
    req_write = 1'b0;
    req_wdata = '0;
    rsp_ready = 1'b1;
    lfsr_q    = 32'd67426;
    wait_cnt  = 3'd0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    n = 0;
    while ((rst_n !== 1'b1) && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("reset was never released");
    end
    fd = $fopen("testbench/apb_golden.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("golden file could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        k = $fgets(line, fd);
        if (k > 1 && line.getc(0) != "#" &&
            $sscanf(line, "%h %h %h %h %h %h %h",
                    f_op, f_addr, f_wdata, f_slot, f_strb, f_rdata, f_err) == 7) begin
          v.op   = f_op[3:0];
          v.req  = '{addr: f_addr, write: f_op[0], wdata: f_wdata};
          v.slot = f_slot[3:0];
          v.strb = f_strb[3:0];
          v.rsp  = '{rdata: f_rdata, err: f_err[0]};
          if (v.op == 4'd2) begin
            burst_q.push_back(v);        // Run together at the end
          end else begin
            err_before = errors;
            tests++;
            run_single(v);
            $display("test %0d %s %h: %s", tests, v.req.write ? "write" : "read",
                     v.req.addr, (errors == err_before) ? "ok" : "errors");
          end
        end
      end
      $fclose(fd);
      if (burst_q.size() > 0) begin
        err_before = errors;
        tests++;
        run_burst();
        $display("test %0d held-back burst of %0d reads: %s", tests, burst_q.size(),
                 (errors == err_before) ? "ok" : "errors");
      end
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clkgen.sv
//------------------------------------------------
// Testbench clock and reset
// 4 ns clock, reset low for the first 10 cycles
//------------------------------------------------
`timescale 1ns/1ns

module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk   = 1'b0;
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    #1 o_rst_n = 1'b1;            // Released off the edge
  end

  always #2 o_clk = ~o_clk;       // 4 ns period

endmodule
